// File: noc_router.f
+incdir+hdl
hdl/noc_router_pkg.sv
hdl/xy_route_compute.sv
hdl/input_buffer.sv
hdl/output_arbiter.sv
hdl/crossbar_switch_inner.sv
hdl/noc_router.sv
verification/noc_router_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= noc_router_tb
FILELIST  ?= noc_router.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench passed" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/noc_router_tb.sv
`timescale 1ns/1ps
`include "noc_router_settings.svh"

module noc_router_tb
   import noc_router_pkg::*;
();

   localparam int          NP          = `NOC_PORTS;
   localparam coord_t      RX          = 2;
   localparam coord_t      RY          = 2;
   localparam int          MAX_C       = (1 << `NOC_COORD_WIDTH) - 1;
   localparam logic [31:0] SEED        = 32'h1da5_accf;
   localparam int          GAP         = 5;
   localparam int          RAND_CYCLES = 300;
   localparam int          FAIR_ROUNDS = 20;
   localparam int          BURST_LEN   = 12;
   localparam int          MAX_WAIT    = 4;
   localparam int          TIMEOUT     = 200;

   logic  clk_i;
   logic  arst_n_i;
   flit_t in_flit   [NP];
   logic  in_valid  [NP];
   flit_t next_flit [NP];
   flit_t out_flit  [NP];
   logic  out_valid [NP];
   logic  out_ovf   [NP];

   // Expected flits wait in one queue per source and output, at index src * NP + out
   flit_t sb_flit  [NP*NP][$];
   int    sb_stamp [NP*NP][$];

   int   inj_cnt  [NP];
   int   del_cnt  [NP];
   int   ovf_cnt  [NP];
   int   lost_cnt [NP];
   int   wait_cnt [NP];
   int   seq      [NP];
   int   ncyc;
   int   total_inj;
   int   total_del;
   int   mismatch_count;
   int   error_count;
   int   fair_port;
   logic check_latency;

   noc_router #(
      .ROUTER_X (RX),
      .ROUTER_Y (RY)
   ) i_dut (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .n_flit_i     (in_flit[PORT_N]),
      .n_valid_i    (in_valid[PORT_N]),
      .n_flit_o     (out_flit[PORT_N]),
      .n_valid_o    (out_valid[PORT_N]),
      .n_overflow_o (out_ovf[PORT_N]),
      .s_flit_i     (in_flit[PORT_S]),
      .s_valid_i    (in_valid[PORT_S]),
      .s_flit_o     (out_flit[PORT_S]),
      .s_valid_o    (out_valid[PORT_S]),
      .s_overflow_o (out_ovf[PORT_S]),
      .w_flit_i     (in_flit[PORT_W]),
      .w_valid_i    (in_valid[PORT_W]),
      .w_flit_o     (out_flit[PORT_W]),
      .w_valid_o    (out_valid[PORT_W]),
      .w_overflow_o (out_ovf[PORT_W]),
      .e_flit_i     (in_flit[PORT_E]),
      .e_valid_i    (in_valid[PORT_E]),
      .e_flit_o     (out_flit[PORT_E]),
      .e_valid_o    (out_valid[PORT_E]),
      .e_overflow_o (out_ovf[PORT_E]),
      .l_flit_i     (in_flit[PORT_L]),
      .l_valid_i    (in_valid[PORT_L]),
      .l_flit_o     (out_flit[PORT_L]),
      .l_valid_o    (out_valid[PORT_L]),
      .l_overflow_o (out_ovf[PORT_L])
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // The XY rule settles x first, then y, and goes local when both match the router position
   function automatic int expected_port(input flit_t f);
      coord_t x;
      coord_t y;
      x = f[15:12];
      y = f[11:8];
      if (x > RX) return int'(PORT_E);
      if (x < RX) return int'(PORT_W);
      if (y > RY) return int'(PORT_N);
      if (y < RY) return int'(PORT_S);
      return int'(PORT_L);
   endfunction

   function automatic flit_t make_flit(input int src, input int dst);
      coord_t x;
      coord_t y;
      x = RX;
      y = coord_t'($urandom);
      case (dst)
         PORT_E:  x = coord_t'(int'(RX) + 1 + int'($urandom % (MAX_C - RX)));
         PORT_W:  x = coord_t'($urandom % RX);
         PORT_N:  y = coord_t'(int'(RY) + 1 + int'($urandom % (MAX_C - RY)));
         PORT_S:  y = coord_t'($urandom % RY);
         default: y = RY;
      endcase
      seq[src] = (seq[src] + 1) % 32;
      return {x, y, 3'(src), 5'(seq[src])};
   endfunction

   // Any output except the one that would send the flit straight back
   function automatic int random_out(input int src);
      int pick;
      pick = int'($urandom % (NP - 1));
      return (pick >= src) ? pick + 1 : pick;
   endfunction

   function automatic int pending_count();
      int n;
      n = 0;
      for (int q = 0; q < NP*NP; q++) n += sb_flit[q].size();
      for (int p = 0; p < NP; p++) n -= ovf_cnt[p] - lost_cnt[p];
      return n;
   endfunction

   function automatic int active_outputs();
      int n;
      n = 0;
      for (int p = 0; p < NP; p++) n += int'(out_valid[p]) + int'(out_ovf[p]);
      return n;
   endfunction

   function automatic int total_overflow();
      int n;
      n = 0;
      for (int p = 0; p < NP; p++) n += ovf_cnt[p];
      return n;
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
      if (got !== exp) begin
         mismatch_count++;
         $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
      end
   endtask

   task automatic step(input logic [NP-1:0] send);
      @(posedge clk_i);
      for (int p = 0; p < NP; p++) begin
         in_valid[p] <= send[p];
         if (send[p]) begin
            in_flit[p] <= next_flit[p];
         end
      end
   endtask

   task automatic wait_drain(input string what);
      int n;
      n = 0;
      repeat (3) @(posedge clk_i);
      while (pending_count() > 0 && n < TIMEOUT) begin
         @(posedge clk_i);
         n++;
      end
      if (pending_count() > 0) begin
         error_count++;
         $display("Timeout: %0d flits of the %s phase never arrived", pending_count(), what);
         // Missing flits are written off so the next phase starts from an empty scoreboard
         for (int p = 0; p < NP; p++) begin
            flush_lost(p);
         end
      end
   endtask

   task automatic clear_counts();
      for (int p = 0; p < NP; p++) begin
         inj_cnt[p]  = 0;
         del_cnt[p]  = 0;
         ovf_cnt[p]  = 0;
         lost_cnt[p] = 0;
         wait_cnt[p] = 0;
      end
   endtask

   // What is still queued after draining was dropped at a full FIFO
   task automatic flush_lost(input int src);
      for (int o = 0; o < NP; o++) begin
         lost_cnt[src] += sb_flit[src*NP + o].size();
         sb_flit[src*NP + o].delete();
         sb_stamp[src*NP + o].delete();
      end
   endtask

   task automatic note_fairness(input int src);
      int q;
      wait_cnt[src] = 0;
      for (int t = 0; t < NP; t++) begin
         q = t * NP + fair_port;
         // A flit strobed two cycles back is already at the head and requesting
         if (t != src && sb_flit[q].size() > 0 && ncyc - sb_stamp[q][0] >= 2) begin
            wait_cnt[t]++;
            check_value(wait_cnt[t] > MAX_WAIT, 0, $sformatf("round-robin wait of input %0d", t));
         end
      end
   endtask

   task automatic receive_flit(input int o, input flit_t f);
      int   src;
      int   q;
      logic done;
      src  = int'(f[7:5]);
      done = 1'b0;
      check_value(o, expected_port(f), $sformatf("output port of flit %h", f));
      if (src >= NP) begin
         error_count++;
         $display("Flit %h on output %0d names no valid source at %0t", f, o, $time);
         return;
      end
      q = src * NP + o;
      while (!done) begin
         if (sb_flit[q].size() == 0) begin
            error_count++;
            $display("Output %0d delivered flit %h that was never sent at %0t", o, f, $time);
            done = 1'b1;
         end else if (sb_flit[q][0] == f || lost_cnt[src] >= ovf_cnt[src]) begin
            check_value(f, sb_flit[q][0], $sformatf("flit order from %0d to %0d", src, o));
            if (check_latency) begin
               check_value(ncyc - sb_stamp[q][0], 2, "latency of a lone flit");
            end
            void'(sb_flit[q].pop_front());
            void'(sb_stamp[q].pop_front());
            del_cnt[src]++;
            total_del++;
            done = 1'b1;
         end else begin
            void'(sb_flit[q].pop_front());
            void'(sb_stamp[q].pop_front());
            lost_cnt[src]++;
         end
      end
      if (o == fair_port) begin
         note_fairness(src);
      end
   endtask

   // Outputs are sampled on the falling edge, half a cycle after they change
   always @(negedge clk_i) begin
      if (arst_n_i) begin
         ncyc++;
         for (int p = 0; p < NP; p++) begin
            if (out_ovf[p]) ovf_cnt[p]++;
            if (in_valid[p]) begin
               sb_flit[p*NP + expected_port(in_flit[p])].push_back(in_flit[p]);
               sb_stamp[p*NP + expected_port(in_flit[p])].push_back(ncyc);
               inj_cnt[p]++;
               total_inj++;
            end
         end
         for (int o = 0; o < NP; o++) begin
            if (out_valid[o]) receive_flit(o, out_flit[o]);
         end
      end
   end

   initial begin
      logic [NP-1:0] send;
      int            cooldown [NP];
      void'($urandom(SEED));
      arst_n_i      = 1'b0;
      check_latency = 1'b0;
      fair_port     = -1;
      for (int p = 0; p < NP; p++) begin
         in_flit[p]   = '0;
         in_valid[p]  = 1'b0;
         next_flit[p] = '0;
         cooldown[p]  = 0;
      end
      repeat (4) @(posedge clk_i);
      arst_n_i <= 1'b1;

      for (int i = 0; i < 8; i++) begin
         @(negedge clk_i);
         check_value(active_outputs(), 0, "outputs active without traffic");
      end

      check_latency = 1'b1;
      for (int s = 0; s < NP; s++) begin
         for (int d = 0; d < NP; d++) begin
            if (d != s) begin
               next_flit[s] = make_flit(s, d);
               send         = '0;
               send[s]      = 1'b1;
               step(send);
               step('0);
               wait_drain("lone flit");
            end
         end
      end
      check_latency = 1'b0;

      for (int c = 0; c < RAND_CYCLES; c++) begin
         send = '0;
         for (int p = 0; p < NP; p++) begin
            if (cooldown[p] > 0) begin
               cooldown[p]--;
            end else if ($urandom % 2 == 1) begin
               send[p]      = 1'b1;
               next_flit[p] = make_flit(p, random_out(p));
               cooldown[p]  = GAP - 1;
            end
         end
         step(send);
      end
      step('0);
      wait_drain("random traffic");
      check_value(total_overflow(), 0, "overflow pulses under light traffic");

      // Four inputs keep the east output busy every cycle
      clear_counts();
      fair_port = int'(PORT_E);
      for (int r = 0; r < FAIR_ROUNDS; r++) begin
         send = '0;
         for (int p = 0; p < NP; p++) begin
            if (p != int'(PORT_E)) begin
               send[p]      = 1'b1;
               next_flit[p] = make_flit(p, PORT_E);
            end
         end
         step(send);
         if (r > 0) begin
            repeat (3) step('0);
         end
      end
      wait_drain("contention");
      fair_port = -1;
      for (int p = 0; p < NP; p++) begin
         if (p != int'(PORT_E)) begin
            check_value(del_cnt[p], FAIR_ROUNDS, $sformatf("flits from input %0d to east", p));
         end
      end

      // West bursts toward east while local holds the same output
      clear_counts();
      for (int i = 0; i < BURST_LEN + 4; i++) begin
         send                 = '0;
         send[PORT_L]         = 1'b1;
         next_flit[PORT_L]    = make_flit(PORT_L, PORT_E);
         if (i < BURST_LEN) begin
            send[PORT_W]      = 1'b1;
            next_flit[PORT_W] = make_flit(PORT_W, PORT_E);
         end
         step(send);
      end
      step('0);
      wait_drain("overflow burst");
      check_value(ovf_cnt[PORT_W] > 0, 1, "overflow pulses on the burst input");
      for (int p = 0; p < NP; p++) begin
         flush_lost(p);
         check_value(del_cnt[p] + ovf_cnt[p], inj_cnt[p],
            $sformatf("delivered plus dropped flits of input %0d", p));
      end

      $display("Run finished: %0d flits sent, %0d delivered, %0d mismatches, %0d other errors",
         total_inj, total_del, mismatch_count, error_count);
      if (mismatch_count == 0 && error_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: hdl/noc_router.sv
`timescale 1ns/1ps

module noc_router
   import noc_router_pkg::*;
#(
   parameter coord_t ROUTER_X = '0,
   parameter coord_t ROUTER_Y = '0
) (
   input  logic  clk_i,
   input  logic  arst_n_i,

   input  flit_t n_flit_i,
   input  logic  n_valid_i,
   output flit_t n_flit_o,
   output logic  n_valid_o,
   output logic  n_overflow_o,

   input  flit_t s_flit_i,
   input  logic  s_valid_i,
   output flit_t s_flit_o,
   output logic  s_valid_o,
   output logic  s_overflow_o,

   input  flit_t w_flit_i,
   input  logic  w_valid_i,
   output flit_t w_flit_o,
   output logic  w_valid_o,
   output logic  w_overflow_o,

   input  flit_t e_flit_i,
   input  logic  e_valid_i,
   output flit_t e_flit_o,
   output logic  e_valid_o,
   output logic  e_overflow_o,

   input  flit_t l_flit_i,
   input  logic  l_valid_i,
   output flit_t l_flit_o,
   output logic  l_valid_o,
   output logic  l_overflow_o
);

   localparam int NPORTS = $bits(port_mask_t);

   flit_t             in_flit   [NPORTS];
   logic [NPORTS-1:0] in_valid;
   logic [NPORTS-1:0] overflow;
   flit_t             head_flit [NPORTS];

   // buf_* are indexed by input port, arb_* by output port
   port_mask_t        buf_req   [NPORTS];
   port_mask_t        buf_grant [NPORTS];
   port_mask_t        arb_req   [NPORTS];
   port_mask_t        arb_grant [NPORTS];

   assign in_flit[PORT_N]  = n_flit_i;
   assign in_flit[PORT_S]  = s_flit_i;
   assign in_flit[PORT_W]  = w_flit_i;
   assign in_flit[PORT_E]  = e_flit_i;
   assign in_flit[PORT_L]  = l_flit_i;

   assign in_valid[PORT_N] = n_valid_i;
   assign in_valid[PORT_S] = s_valid_i;
   assign in_valid[PORT_W] = w_valid_i;
   assign in_valid[PORT_E] = e_valid_i;
   assign in_valid[PORT_L] = l_valid_i;

   assign n_overflow_o = overflow[PORT_N];
   assign s_overflow_o = overflow[PORT_S];
   assign w_overflow_o = overflow[PORT_W];
   assign e_overflow_o = overflow[PORT_E];
   assign l_overflow_o = overflow[PORT_L];

   for (genvar p = 0; p < NPORTS; p++) begin : g_port
      input_buffer #(
         .ROUTER_X (ROUTER_X),
         .ROUTER_Y (ROUTER_Y),
         .IN_PORT  (port_e'(p))
      ) i_input_buffer (
         .clk_i       (clk_i),
         .arst_n_i    (arst_n_i),
         .flit_i      (in_flit[p]),
         .valid_i     (in_valid[p]),
         .grant_i     (buf_grant[p]),
         .head_flit_o (head_flit[p]),
         .req_o       (buf_req[p]),
         .overflow_o  (overflow[p])
      );

      output_arbiter #(
         .OUT_PORT (port_e'(p))
      ) i_output_arbiter (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .req_i    (arb_req[p]),
         .grant_o  (arb_grant[p])
      );

      // Requests are gathered per output and grants handed back per input
      for (genvar q = 0; q < NPORTS; q++) begin : g_xpose
         assign arb_req[p][q]   = buf_req[q][p];
         assign buf_grant[p][q] = arb_grant[q][p];
      end
   end

   crossbar_switch_inner i_crossbar_switch_inner (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .n_flit_i  (head_flit[PORT_N]),
      .s_flit_i  (head_flit[PORT_S]),
      .w_flit_i  (head_flit[PORT_W]),
      .e_flit_i  (head_flit[PORT_E]),
      .l_flit_i  (head_flit[PORT_L]),
      .n_grant_i (arb_grant[PORT_N]),
      .s_grant_i (arb_grant[PORT_S]),
      .w_grant_i (arb_grant[PORT_W]),
      .e_grant_i (arb_grant[PORT_E]),
      .l_grant_i (arb_grant[PORT_L]),
      .n_flit_o  (n_flit_o),
      .s_flit_o  (s_flit_o),
      .w_flit_o  (w_flit_o),
      .e_flit_o  (e_flit_o),
      .l_flit_o  (l_flit_o),
      .n_valid_o (n_valid_o),
      .s_valid_o (s_valid_o),
      .w_valid_o (w_valid_o),
      .e_valid_o (e_valid_o),
      .l_valid_o (l_valid_o)
   );

endmodule

// File: hdl/crossbar_switch_inner.sv
`timescale 1ns/1ps

module crossbar_switch_inner
   import noc_router_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,

   input  flit_t      n_flit_i,
   input  flit_t      s_flit_i,
   input  flit_t      w_flit_i,
   input  flit_t      e_flit_i,
   input  flit_t      l_flit_i,

   input  port_mask_t n_grant_i,
   input  port_mask_t s_grant_i,
   input  port_mask_t w_grant_i,
   input  port_mask_t e_grant_i,
   input  port_mask_t l_grant_i,

   output flit_t      n_flit_o,
   output flit_t      s_flit_o,
   output flit_t      w_flit_o,
   output flit_t      e_flit_o,
   output flit_t      l_flit_o,

   output logic       n_valid_o,
   output logic       s_valid_o,
   output logic       w_valid_o,
   output logic       e_valid_o,
   output logic       l_valid_o
);

   localparam int NPORTS = $bits(port_mask_t);

   flit_t      in_flit    [NPORTS];
   port_mask_t grant      [NPORTS];
   flit_t      out_flit_q [NPORTS];
   logic       out_valid_q [NPORTS];

   assign in_flit[PORT_N] = n_flit_i;
   assign in_flit[PORT_S] = s_flit_i;
   assign in_flit[PORT_W] = w_flit_i;
   assign in_flit[PORT_E] = e_flit_i;
   assign in_flit[PORT_L] = l_flit_i;

   // Grant vector j belongs to output j, bit i selects input i
   assign grant[PORT_N] = n_grant_i;
   assign grant[PORT_S] = s_grant_i;
   assign grant[PORT_W] = w_grant_i;
   assign grant[PORT_E] = e_grant_i;
   assign grant[PORT_L] = l_grant_i;

   for (genvar j = 0; j < NPORTS; j++) begin : g_out
      port_mask_t sel_grant;
      flit_t      sel_flit;

      assign sel_grant = grant[j] & ~(port_mask_t'(1) << j);

      always_comb begin
         sel_flit = '0;
         for (int i = 0; i < NPORTS; i++) begin
            if (sel_grant[i]) begin
               sel_flit = in_flit[i];
            end
         end
      end

      always_ff @(posedge clk_i) begin
         if (|sel_grant) begin
            out_flit_q[j] <= sel_flit;
         end
      end

      always_ff @(posedge clk_i or negedge arst_n_i) begin
         if (!arst_n_i) begin
            out_valid_q[j] <= 1'b0;
         end else begin
            out_valid_q[j] <= |sel_grant;
         end
      end
   end

   assign n_flit_o  = out_flit_q[PORT_N];
   assign s_flit_o  = out_flit_q[PORT_S];
   assign w_flit_o  = out_flit_q[PORT_W];
   assign e_flit_o  = out_flit_q[PORT_E];
   assign l_flit_o  = out_flit_q[PORT_L];

   assign n_valid_o = out_valid_q[PORT_N];
   assign s_valid_o = out_valid_q[PORT_S];
   assign w_valid_o = out_valid_q[PORT_W];
   assign e_valid_o = out_valid_q[PORT_E];
   assign l_valid_o = out_valid_q[PORT_L];

endmodule

// File: hdl/output_arbiter.sv
`timescale 1ns/1ps

module output_arbiter
   import noc_router_pkg::*;
#(
   parameter port_e OUT_PORT = PORT_L
) (
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  port_mask_t req_i,
   output port_mask_t grant_o
);

   localparam int NPORTS = $bits(port_mask_t);

   port_e      last_q;
   port_e      next_last;
   port_mask_t req_masked;

   // An output never serves its own input
   assign req_masked = req_i & ~(port_mask_t'(1) << OUT_PORT);

   // Scan starts just after the last winner and wraps around to it
   always_comb begin
      int   idx;
      logic found;
      grant_o   = '0;
      next_last = last_q;
      found     = 1'b0;
      for (int off = 1; off <= NPORTS; off++) begin
         idx = (int'(last_q) + off) % NPORTS;
         if (!found && req_masked[idx]) begin
            grant_o[idx] = 1'b1;
            next_last    = port_e'(idx);
            found        = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         last_q <= OUT_PORT;
      end else if (|grant_o) begin
         last_q <= next_last;
      end
   end

   a_grant_legal : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(grant_o) && !grant_o[OUT_PORT])
      else $error("Illegal grant %b on output %0d", grant_o, OUT_PORT);

   // A waiting input is not passed over by the same winner twice in a row
   a_no_repeat_winner : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (|grant_o && ((req_masked & ~grant_o) != '0)) |=>
         (grant_o != $past(grant_o)) || ((req_masked & ~grant_o) == '0))
      else $error("Output %0d granted the same input twice over a waiting one", OUT_PORT);

endmodule

// File: hdl/input_buffer.sv
`timescale 1ns/1ps
`include "noc_router_settings.svh"

module input_buffer
   import noc_router_pkg::*;
#(
   parameter coord_t ROUTER_X = '0,
   parameter coord_t ROUTER_Y = '0,
   parameter port_e  IN_PORT  = PORT_L
) (
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  flit_t      flit_i,
   input  logic       valid_i,
   input  port_mask_t grant_i,
   output flit_t      head_flit_o,
   output port_mask_t req_o,
   output logic       overflow_o
);

   localparam int DEPTH = `NOC_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   flit_t            mem_q [DEPTH];
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W-1:0] wr_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             empty;
   logic             full;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign empty = (count_q == '0);
   assign full  = (count_q == CNT_W'(DEPTH));
   assign pop   = (|grant_i) && !empty;

   // A full FIFO still takes a flit when its head leaves in the same cycle
   assign push  = valid_i && (!full || pop);

   assign head_flit_o = mem_q[rd_ptr_q];

   xy_route_compute #(
      .ROUTER_X (ROUTER_X),
      .ROUTER_Y (ROUTER_Y),
      .IN_PORT  (IN_PORT)
   ) i_xy_route_compute (
      .flit_i  (head_flit_o),
      .valid_i (!empty),
      .req_o   (req_o)
   );

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wr_ptr_q] <= flit_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_ptr_q   <= '0;
         wr_ptr_q   <= '0;
         count_q    <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         overflow_o <= valid_i && !push;
      end
   end

   // Only one output may take the head flit, and only the one it asked for
   a_grant_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(grant_i))
      else $error("Head flit of port %0d granted to several outputs", IN_PORT);

   a_grant_requested : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (grant_i & ~req_o) == '0)
      else $error("Port %0d granted an output it did not request", IN_PORT);

endmodule

// File: hdl/xy_route_compute.sv
`timescale 1ns/1ps

module xy_route_compute
   import noc_router_pkg::*;
#(
   parameter coord_t ROUTER_X = '0,
   parameter coord_t ROUTER_Y = '0,
   parameter port_e  IN_PORT  = PORT_L
) (
   input  flit_t      flit_i,
   input  logic       valid_i,
   output port_mask_t req_o
);

   localparam int FLIT_W  = $bits(flit_t);
   localparam int COORD_W = $bits(coord_t);

   coord_t dst_x;
   coord_t dst_y;

   assign dst_x = flit_i[FLIT_W-1 -: COORD_W];
   assign dst_y = flit_i[FLIT_W-COORD_W-1 -: COORD_W];

   // X is resolved completely before Y is looked at
   always_comb begin
      req_o = '0;
      if (valid_i) begin
         if (dst_x > ROUTER_X) begin
            req_o[PORT_E] = 1'b1;
         end else if (dst_x < ROUTER_X) begin
            req_o[PORT_W] = 1'b1;
         end else if (dst_y > ROUTER_Y) begin
            req_o[PORT_N] = 1'b1;
         end else if (dst_y < ROUTER_Y) begin
            req_o[PORT_S] = 1'b1;
         end else begin
            req_o[PORT_L] = 1'b1;
         end
      end
   end

   // A neighbour that routes by XY never hands over a flit that must go back to it
   always_comb begin
      if (valid_i) begin
         assert (!req_o[IN_PORT])
            else $error("U-turn request toward input port %0d", IN_PORT);
      end
   end

endmodule

// File: hdl/noc_router_pkg.sv
`include "noc_router_settings.svh"

package noc_router_pkg;

   // Flit layout is dst_x in the top nibble, dst_y below it, payload in the low byte
   typedef logic [`NOC_FLIT_WIDTH-1:0] flit_t;

   typedef logic [`NOC_COORD_WIDTH-1:0] coord_t;

   // One bit per port, indexed by port_e
   typedef logic [`NOC_PORTS-1:0] port_mask_t;

   typedef enum logic [2:0] {
      PORT_N = 3'd0,
      PORT_S = 3'd1,
      PORT_W = 3'd2,
      PORT_E = 3'd3,
      PORT_L = 3'd4
   } port_e;

endpackage

// File: hdl/noc_router_settings.svh
`ifndef NOC_ROUTER_SETTINGS_SVH
`define NOC_ROUTER_SETTINGS_SVH

// One flit carries destination x, destination y and an 8-bit payload
`define NOC_FLIT_WIDTH 16

// Width of one mesh coordinate inside the flit header
`define NOC_COORD_WIDTH 4

// Entries in each input FIFO
`define NOC_FIFO_DEPTH 4

// North, south, west, east and local
`define NOC_PORTS 5

`endif
